/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := burst_buf_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/burst_buf_pkg.sv */
`default_nettype none

package burst_buf_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizing
    //////////////////////////////////////////////////////////////////////

    // Samples held by the FIFO
    localparam int FIFO_DEPTH = 16;

    // Samples per output burst
    localparam int BURST_LEN = 4;

    // Almost-full asserts at FIFO_DEPTH - ALMOST_FULL_MARGIN and above
    localparam int ALMOST_FULL_MARGIN = 2;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0] sample_t;

    // Fill count, 0 to FIFO_DEPTH inclusive
    typedef logic [4:0] level_t;

    // Saturating drop count
    typedef logic [7:0] drop_count_t;

    typedef enum logic {
        DRAIN_IDLE = 1'b0,
        DRAIN_READ = 1'b1
    } drain_state_t;

endpackage : burst_buf_pkg

`default_nettype wire

/* logic/burst_buf_top.sv */
`default_nettype none

module burst_buf_top (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_in_stb,
    input  burst_buf_pkg::sample_t       i_in_data,
    input  wire logic                    i_drain_en,
    output logic                         o_out_stb,
    output burst_buf_pkg::sample_t       o_out_data,
    output logic                         o_out_last,
    output burst_buf_pkg::level_t        o_level,
    output logic                         o_full,
    output logic                         o_almost_full,
    output burst_buf_pkg::drop_count_t   o_drop_count
);

    logic                   w_wr_stb;
    burst_buf_pkg::sample_t w_wr_data;
    logic                   w_rd_stb;
    burst_buf_pkg::sample_t w_rd_data;
    logic                   w_empty;

    // Input side, drops on full
    sample_ingress u_ingress (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_in_stb     (i_in_stb),
        .i_in_data    (i_in_data),
        .i_full       (o_full),
        .o_wr_stb     (w_wr_stb),
        .o_wr_data    (w_wr_data),
        .o_drop_count (o_drop_count)
    );

    // Sample store, empty flag stays internal
    fifo_sync #(
        .DEPTH (burst_buf_pkg::FIFO_DEPTH)
    ) u_fifo (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_wr_stb      (w_wr_stb),
        .i_wr_data     (w_wr_data),
        .i_rd_stb      (w_rd_stb),
        .o_rd_data     (w_rd_data),
        .o_level       (o_level),
        .o_full        (o_full),
        .o_almost_full (o_almost_full),
        .o_empty       (w_empty)
    );

    // Output side, whole bursts only
    burst_drain u_drain (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_drain_en (i_drain_en),
        .i_level    (o_level),
        .i_rd_data  (w_rd_data),
        .o_rd_stb   (w_rd_stb),
        .o_out_stb  (o_out_stb),
        .o_out_data (o_out_data),
        .o_out_last (o_out_last)
    );

endmodule : burst_buf_top

`default_nettype wire

/* logic/burst_drain.sv */
`default_nettype none

module burst_drain (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_drain_en,
    input  burst_buf_pkg::level_t        i_level,
    input  burst_buf_pkg::sample_t       i_rd_data,
    output logic                         o_rd_stb,
    output logic                         o_out_stb,
    output burst_buf_pkg::sample_t       o_out_data,
    output logic                         o_out_last
);

    localparam int BEAT_W = $clog2(burst_buf_pkg::BURST_LEN);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(burst_buf_pkg::BURST_LEN - 1);
    localparam burst_buf_pkg::level_t BURST_LEVEL =
        burst_buf_pkg::level_t'(burst_buf_pkg::BURST_LEN);

    burst_buf_pkg::drain_state_t r_state;
    logic [BEAT_W-1:0]           r_beat;
    logic                        w_burst_ready;
    logic                        w_last_beat;

    // A whole burst must be stored before reading starts
    assign w_burst_ready = (i_level >= BURST_LEVEL);

    assign o_rd_stb    = (r_state == burst_buf_pkg::DRAIN_READ);
    assign w_last_beat = o_rd_stb && (r_beat == LAST_BEAT);

    //////////////////////////////////////////////////////////////////////
    // Drain FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state <= burst_buf_pkg::DRAIN_IDLE;
            r_beat  <= '0;
        end else begin
            case (r_state)
                burst_buf_pkg::DRAIN_IDLE: begin
                    r_beat <= '0;
                    if (i_drain_en && w_burst_ready) begin
                        r_state <= burst_buf_pkg::DRAIN_READ;
                    end
                end
                burst_buf_pkg::DRAIN_READ: begin
                    // Enable is ignored until the burst is done
                    r_beat <= r_beat + 1'b1;
                    if (w_last_beat) begin
                        r_state <= burst_buf_pkg::DRAIN_IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output alignment with registered read data
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_stb  <= 1'b0;
            o_out_last <= 1'b0;
        end else begin
            o_out_stb  <= o_rd_stb;
            o_out_last <= w_last_beat;
        end
    end

    assign o_out_data = i_rd_data;

endmodule : burst_drain

`default_nettype wire

/* logic/counter_bin.sv */
`default_nettype none

module counter_bin #(
    parameter int WIDTH = 5,
    parameter int MAX   = 16
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_enable,
    output logic      [WIDTH-1:0] o_counter_bin,
    output logic      [WIDTH-1:0] o_counter_bin_next
);

    // Address part below the wrap bit
    localparam logic [WIDTH-2:0] LAST_ADDR = (WIDTH - 1)'(MAX - 1);

    logic w_at_last;

    assign w_at_last = (o_counter_bin[WIDTH-2:0] == LAST_ADDR);

    // Next value, address wraps at MAX and flips the top bit
    always_comb begin
        o_counter_bin_next = o_counter_bin;
        if (i_enable) begin
            if (w_at_last) begin
                o_counter_bin_next = {~o_counter_bin[WIDTH-1], {(WIDTH - 1) {1'b0}}};
            end else begin
                o_counter_bin_next = o_counter_bin + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_counter_bin <= '0;
        end else begin
            o_counter_bin <= o_counter_bin_next;
        end
    end

endmodule : counter_bin

`default_nettype wire

/* logic/fifo_control.sv */
`default_nettype none

module fifo_control #(
    parameter int DEPTH = 16
) (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic   [$clog2(DEPTH):0]      i_wr_ptr_next,
    input  wire logic   [$clog2(DEPTH):0]      i_rd_ptr_next,
    output burst_buf_pkg::level_t              o_level,
    output logic                               o_full,
    output logic                               o_almost_full,
    output logic                               o_empty
);

    localparam int AW = $clog2(DEPTH);

    // Flag thresholds in fill count units
    localparam burst_buf_pkg::level_t FULL_LEVEL = burst_buf_pkg::level_t'(DEPTH);
    localparam burst_buf_pkg::level_t ALMOST_FULL_LEVEL =
        burst_buf_pkg::level_t'(DEPTH - burst_buf_pkg::ALMOST_FULL_MARGIN);

    logic [AW-1:0] w_wr_addr;
    logic [AW-1:0] w_rd_addr;
    logic          w_same_lap;

    burst_buf_pkg::level_t w_level_next;

    //////////////////////////////////////////////////////////////////////
    // Fill count from the next pointers
    //////////////////////////////////////////////////////////////////////

    assign w_wr_addr  = i_wr_ptr_next[AW-1:0];
    assign w_rd_addr  = i_rd_ptr_next[AW-1:0];
    assign w_same_lap = (i_wr_ptr_next[AW] == i_rd_ptr_next[AW]);

    always_comb begin
        if (w_same_lap) begin
            w_level_next = burst_buf_pkg::level_t'(w_wr_addr)
                         - burst_buf_pkg::level_t'(w_rd_addr);
        end else begin
            // Writer is one lap ahead
            w_level_next = FULL_LEVEL
                         + burst_buf_pkg::level_t'(w_wr_addr)
                         - burst_buf_pkg::level_t'(w_rd_addr);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Registered flags, valid the cycle after each access
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_level       <= '0;
            o_full        <= 1'b0;
            o_almost_full <= 1'b0;
            o_empty       <= 1'b1;
        end else begin
            o_level       <= w_level_next;
            o_full        <= (w_level_next == FULL_LEVEL);
            o_almost_full <= (w_level_next >= ALMOST_FULL_LEVEL);
            o_empty       <= (w_level_next == '0);
        end
    end

endmodule : fifo_control

`default_nettype wire

/* logic/fifo_sync.sv */
`default_nettype none

module fifo_sync #(
    parameter int DEPTH = 16
) (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_wr_stb,
    input  burst_buf_pkg::sample_t       i_wr_data,
    input  wire logic                    i_rd_stb,
    output burst_buf_pkg::sample_t       o_rd_data,
    output burst_buf_pkg::level_t        o_level,
    output logic                         o_full,
    output logic                         o_almost_full,
    output logic                         o_empty
);

    localparam int AW = $clog2(DEPTH);

    // Pointers carry one wrap bit above the address
    logic [AW:0] r_wr_ptr;
    logic [AW:0] r_rd_ptr;
    logic [AW:0] w_wr_ptr_next;
    logic [AW:0] w_rd_ptr_next;

    logic [AW-1:0] w_wr_addr;
    logic [AW-1:0] w_rd_addr;

    burst_buf_pkg::sample_t r_mem [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Pointer counters
    //////////////////////////////////////////////////////////////////////

    // Writes are trusted, the producer already checked full
    counter_bin #(
        .WIDTH (AW + 1),
        .MAX   (DEPTH)
    ) u_wr_ptr (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_enable           (i_wr_stb),
        .o_counter_bin      (r_wr_ptr),
        .o_counter_bin_next (w_wr_ptr_next)
    );

    // Reads are trusted as well
    counter_bin #(
        .WIDTH (AW + 1),
        .MAX   (DEPTH)
    ) u_rd_ptr (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_enable           (i_rd_stb),
        .o_counter_bin      (r_rd_ptr),
        .o_counter_bin_next (w_rd_ptr_next)
    );

    //////////////////////////////////////////////////////////////////////
    // Level and flags
    //////////////////////////////////////////////////////////////////////

    fifo_control #(
        .DEPTH (DEPTH)
    ) u_control (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_wr_ptr_next (w_wr_ptr_next),
        .i_rd_ptr_next (w_rd_ptr_next),
        .o_level       (o_level),
        .o_full        (o_full),
        .o_almost_full (o_almost_full),
        .o_empty       (o_empty)
    );

    //////////////////////////////////////////////////////////////////////
    // Storage and read data stage
    //////////////////////////////////////////////////////////////////////

    assign w_wr_addr = r_wr_ptr[AW-1:0];
    assign w_rd_addr = r_rd_ptr[AW-1:0];

    always_ff @(posedge i_clk) begin
        if (i_wr_stb) begin
            r_mem[w_wr_addr] <= i_wr_data;
        end
    end

    // Head entry sampled every cycle, so a read shows up one cycle later
    always_ff @(posedge i_clk) begin
        o_rd_data <= r_mem[w_rd_addr];
    end

endmodule : fifo_sync

`default_nettype wire

/* logic/sample_ingress.sv */
`default_nettype none

module sample_ingress (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_in_stb,
    input  burst_buf_pkg::sample_t       i_in_data,
    input  wire logic                    i_full,
    output logic                         o_wr_stb,
    output burst_buf_pkg::sample_t       o_wr_data,
    output burst_buf_pkg::drop_count_t   o_drop_count
);

    logic                   r_in_stb;
    burst_buf_pkg::sample_t r_in_data;
    logic                   w_drop;

    //////////////////////////////////////////////////////////////////////
    // Input register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_in_stb <= 1'b0;
        end else begin
            r_in_stb <= i_in_stb;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_in_stb) begin
            r_in_data <= i_in_data;
        end
    end

    // Full is checked here, the FIFO itself does not gate writes
    assign o_wr_stb  = r_in_stb && !i_full;
    assign o_wr_data = r_in_data;
    assign w_drop    = r_in_stb && i_full;

    // Drop counter holds at all ones
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_drop_count <= '0;
        end else if (w_drop && (o_drop_count != '1)) begin
            o_drop_count <= o_drop_count + 1'b1;
        end
    end

endmodule : sample_ingress

`default_nettype wire

/* tb.f */
logic/burst_buf_pkg.sv
logic/counter_bin.sv
logic/fifo_control.sv
logic/fifo_sync.sv
logic/sample_ingress.sv
logic/burst_drain.sv
logic/burst_buf_top.sv
verification/burst_buf_assert.sv
verification/burst_buf_tb.sv

/* verification/burst_buf_assert.sv */
`default_nettype none

module burst_buf_assert (
    input  wire logic                                       i_clk,
    input  wire logic                                       i_rst_n,
    input  wire logic                                       i_wr_stb,
    input  wire logic                                       i_rd_stb,
    input  wire logic                                       i_full,
    input  wire logic                                       i_empty,
    input  wire logic [$clog2(burst_buf_pkg::FIFO_DEPTH):0] i_wr_ptr,
    input  wire logic [$clog2(burst_buf_pkg::FIFO_DEPTH):0] i_rd_ptr,
    input  wire logic                                       i_out_stb,
    input  wire logic                                       i_out_last,
    input  burst_buf_pkg::drain_state_t                     i_state
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int AW = $clog2(burst_buf_pkg::FIFO_DEPTH);

    logic w_ptr_full;
    logic w_ptr_empty;

    // Fill state seen from the pointer pair alone
    assign w_ptr_empty = (i_wr_ptr == i_rd_ptr);
    assign w_ptr_full  = (i_wr_ptr[AW-1:0] == i_rd_ptr[AW-1:0])
                      && (i_wr_ptr[AW] != i_rd_ptr[AW]);

    // FIFO protocol against the pointer pair
    a_no_write_when_full : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wr_stb |-> !w_ptr_full)
        else $error("FIFO write while full");

    a_no_read_when_empty : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rd_stb |-> !i_empty)
        else $error("FIFO read while empty");

    // Registered flags track the pointers, so full and empty never meet
    a_flags_match_ptrs : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_full == w_ptr_full) && (i_empty == w_ptr_empty))
        else $error("FIFO flags disagree with the pointers");

    // A burst is BURST_LEN reads in a row
    a_burst_length : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == burst_buf_pkg::DRAIN_IDLE)
            && ($past(i_state) == burst_buf_pkg::DRAIN_READ)
        |-> ($past(i_state, burst_buf_pkg::BURST_LEN) == burst_buf_pkg::DRAIN_READ)
            && ($past(i_state, burst_buf_pkg::BURST_LEN + 1) == burst_buf_pkg::DRAIN_IDLE))
        else $error("Burst length differs from BURST_LEN reads");

    // Strobe run ends right after the marked sample
    a_last_ends_burst : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_out_stb) == $past(i_out_last))
        else $error("Output burst not closed by its last marker");

endmodule : burst_buf_assert

`default_nettype wire

/* verification/burst_buf_tb.sv */
`default_nettype none

module burst_buf_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES    = 2000;
    localparam int OUTPUT_WAIT_LIMIT = 200;
    localparam int SETTLE_CYCLES     = 10;
    localparam int RANDOM_SEED       = 86704;
    localparam int OVERFLOW_SAMPLES  = 20;
    localparam int STREAM_SAMPLES    = 60;

    logic                        i_clk;
    logic                        i_rst_n;
    logic                        i_in_stb;
    burst_buf_pkg::sample_t      i_in_data;
    logic                        i_drain_en;
    logic                        o_out_stb;
    burst_buf_pkg::sample_t      o_out_data;
    logic                        o_out_last;
    burst_buf_pkg::level_t       o_level;
    logic                        o_full;
    logic                        o_almost_full;
    burst_buf_pkg::drop_count_t  o_drop_count;

    burst_buf_pkg::sample_t expected_q[$];
    burst_buf_pkg::sample_t monitor_data;
    logic                   monitor_last;
    int                     out_count = 0;
    int                     out_beat = 0;
    int                     error_count = 0;
    int                     tests_passed = 0;
    int                     tests_failed = 0;
    int                     cycle_count = 0;
    int                     expected_drops = 0;

    burst_buf_top dut (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_in_stb      (i_in_stb),
        .i_in_data     (i_in_data),
        .i_drain_en    (i_drain_en),
        .o_out_stb     (o_out_stb),
        .o_out_data    (o_out_data),
        .o_out_last    (o_out_last),
        .o_level       (o_level),
        .o_full        (o_full),
        .o_almost_full (o_almost_full),
        .o_drop_count  (o_drop_count)
    );

    bind burst_buf_top burst_buf_assert u_assert (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_stb   (w_wr_stb),
        .i_rd_stb   (w_rd_stb),
        .i_full     (o_full),
        .i_empty    (w_empty),
        .i_wr_ptr   (u_fifo.r_wr_ptr),
        .i_rd_ptr   (u_fifo.r_rd_ptr),
        .i_out_stb  (o_out_stb),
        .i_out_last (o_out_last),
        .i_state    (u_drain.r_state)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %0t ns %s expected %0h got %0h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor comparing each strobe with the reference queue
    //////////////////////////////////////////////////////////////////////

    always @(negedge i_clk) begin
        if (i_rst_n && o_out_stb) begin
            if (expected_q.size() == 0) begin
                report_failure("output strobe while no stored sample was expected");
            end else begin
                monitor_data = expected_q.pop_front();
                if (o_out_data !== monitor_data) begin
                    report_mismatch("o_out_data", 32'(monitor_data), 32'(o_out_data));
                end
            end
            monitor_last = (out_beat == burst_buf_pkg::BURST_LEN - 1);
            if (o_out_last !== monitor_last) begin
                report_mismatch("o_out_last", 32'(monitor_last), 32'(o_out_last));
            end
            out_beat = (out_beat + 1) % burst_buf_pkg::BURST_LEN;
            out_count++;
        end else if (i_rst_n) begin
            if (out_beat != 0) begin
                report_failure("output burst broke off before its last sample");
                out_beat = 0;
            end
            if (o_out_last !== 1'b0) begin
                report_mismatch("o_out_last", 32'(1'b0), 32'(o_out_last));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers that start and end on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge i_clk);
    endtask

    // Drives one input strobe and queues the sample when it will be kept
    task automatic write_sample(input burst_buf_pkg::sample_t value, input bit kept);
        i_in_stb  = 1'b1;
        i_in_data = value;
        if (kept) begin
            expected_q.push_back(value);
        end
        @(negedge i_clk);
        i_in_stb = 1'b0;
    endtask

    task automatic wait_for_outputs(input int target);
        int waited;
        waited = 0;
        while (out_count < target && waited < OUTPUT_WAIT_LIMIT) begin
            @(posedge i_clk);
            waited++;
        end
        if (out_count < target) begin
            report_failure($sformatf("only %0d of %0d output samples arrived",
                                     out_count, target));
        end
        @(negedge i_clk);
    endtask

    task automatic check_settled(input int expected_outputs, input int expected_held);
        if (out_count != expected_outputs) begin
            report_mismatch("output strobe count", 32'(expected_outputs), 32'(out_count));
        end
        if (o_level !== burst_buf_pkg::level_t'(expected_held)) begin
            report_mismatch("o_level", 32'(expected_held), 32'(o_level));
        end
        if (expected_q.size() != expected_held) begin
            report_mismatch("held samples", 32'(expected_held), 32'(expected_q.size()));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_after_reset();
        int errors_before;
        errors_before = error_count;
        if (o_out_stb !== 1'b0) report_mismatch("o_out_stb", 32'(0), 32'(o_out_stb));
        if (o_out_last !== 1'b0) report_mismatch("o_out_last", 32'(0), 32'(o_out_last));
        if (o_full !== 1'b0) report_mismatch("o_full", 32'(0), 32'(o_full));
        if (o_almost_full !== 1'b0) begin
            report_mismatch("o_almost_full", 32'(0), 32'(o_almost_full));
        end
        if (o_level !== '0) report_mismatch("o_level", 32'(0), 32'(o_level));
        if (o_drop_count !== '0) report_mismatch("o_drop_count", 32'(0), 32'(o_drop_count));
        finish_test("after reset", errors_before);
    endtask

    task automatic test_one_burst();
        int errors_before;
        int base;
        errors_before = error_count;
        base = out_count;
        i_drain_en = 1'b1;
        for (int i = 0; i < burst_buf_pkg::BURST_LEN; i++) begin
            write_sample(burst_buf_pkg::sample_t'($urandom), 1'b1);
        end
        wait_for_outputs(base + burst_buf_pkg::BURST_LEN);
        wait_cycles(SETTLE_CYCLES);
        check_settled(base + burst_buf_pkg::BURST_LEN, 0);
        finish_test("one burst", errors_before);
    endtask

    task automatic test_partial_burst();
        int errors_before;
        int base;
        errors_before = error_count;
        base = out_count;
        i_drain_en = 1'b1;
        for (int i = 0; i < burst_buf_pkg::BURST_LEN - 1; i++) begin
            write_sample(burst_buf_pkg::sample_t'($urandom), 1'b1);
        end
        // Three stored samples must stay put
        wait_cycles(20);
        check_settled(base, burst_buf_pkg::BURST_LEN - 1);
        write_sample(burst_buf_pkg::sample_t'($urandom), 1'b1);
        wait_for_outputs(base + burst_buf_pkg::BURST_LEN);
        wait_cycles(SETTLE_CYCLES);
        check_settled(base + burst_buf_pkg::BURST_LEN, 0);
        finish_test("partial burst", errors_before);
    endtask

    task automatic test_overflow();
        int errors_before;
        int base;
        errors_before = error_count;
        base = out_count;
        i_drain_en = 1'b0;
        // Only the first FIFO_DEPTH samples fit
        for (int i = 0; i < OVERFLOW_SAMPLES; i++) begin
            write_sample(burst_buf_pkg::sample_t'($urandom), i < burst_buf_pkg::FIFO_DEPTH);
        end
        expected_drops = expected_drops + OVERFLOW_SAMPLES - burst_buf_pkg::FIFO_DEPTH;
        wait_cycles(3);
        if (o_full !== 1'b1) report_mismatch("o_full", 32'(1), 32'(o_full));
        if (o_almost_full !== 1'b1) begin
            report_mismatch("o_almost_full", 32'(1), 32'(o_almost_full));
        end
        check_settled(base, burst_buf_pkg::FIFO_DEPTH);
        if (o_drop_count !== burst_buf_pkg::drop_count_t'(expected_drops)) begin
            report_mismatch("o_drop_count", 32'(expected_drops), 32'(o_drop_count));
        end
        i_drain_en = 1'b1;
        wait_for_outputs(base + burst_buf_pkg::FIFO_DEPTH);
        wait_cycles(SETTLE_CYCLES);
        check_settled(base + burst_buf_pkg::FIFO_DEPTH, 0);
        if (o_full !== 1'b0) report_mismatch("o_full", 32'(0), 32'(o_full));
        if (o_drop_count !== burst_buf_pkg::drop_count_t'(expected_drops)) begin
            report_mismatch("o_drop_count", 32'(expected_drops), 32'(o_drop_count));
        end
        finish_test("overflow", errors_before);
    endtask

    task automatic test_random_stream();
        int errors_before;
        int base;
        int held;
        errors_before = error_count;
        base = out_count;
        held = STREAM_SAMPLES % burst_buf_pkg::BURST_LEN;
        i_drain_en = 1'b1;
        // Gaps keep the input slower than the drain
        for (int i = 0; i < STREAM_SAMPLES; i++) begin
            write_sample(burst_buf_pkg::sample_t'($urandom), 1'b1);
            wait_cycles($urandom_range(1, 3));
        end
        wait_for_outputs(base + STREAM_SAMPLES - held);
        wait_cycles(SETTLE_CYCLES);
        check_settled(base + STREAM_SAMPLES - held, held);
        if (o_drop_count !== burst_buf_pkg::drop_count_t'(expected_drops)) begin
            report_mismatch("o_drop_count", 32'(expected_drops), 32'(o_drop_count));
        end
        finish_test("random stream", errors_before);
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_in_stb   = 1'b0;
        i_in_data  = '0;
        i_drain_en = 1'b0;
        void'($urandom(RANDOM_SEED));
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);

        test_after_reset();
        test_one_burst();
        test_partial_burst();
        test_overflow();
        test_random_stream();

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : burst_buf_tb

`default_nettype wire
